/* Bender.yml */
package:
  name: display_link

sources:
  # package first, then leaf modules, then the top level
  - files:
      - logic/display_link_pkg.sv
      - logic/han_carlson_adder.sv
      - logic/pixel_line_ram.sv
      - logic/line_sequencer.sv
      - logic/serial_display_tx.sv
      - logic/display_link_top.sv

  # testbench top is display_link_tb
  - target: test
    files:
      - tb/display_link_tb.sv

/* display_link_top.f */
logic/display_link_pkg.sv
logic/han_carlson_adder.sv
logic/pixel_line_ram.sv
logic/line_sequencer.sv
logic/serial_display_tx.sv
logic/display_link_top.sv
tb/display_link_tb.sv

/* logic/display_link_pkg.sv */
// shared types and default sizes for the serial display link
// RGB888 pixels, RGB565 word views, host write and line command records
`default_nettype none

package display_link_pkg;

    // default line buffer size for the module parameters
    localparam int LINE_DEPTH = 32;
    localparam int ADDR_W     = 5;

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb888_t;

    typedef struct packed {
        logic [4:0] red;
        logic [5:0] green;
        logic [4:0] blue;
    } rgb565_t;

    // field view for conversion, raw view for shifting
    typedef union packed {
        rgb565_t     fields;
        logic [15:0] raw;
    } rgb565_u;

    typedef struct packed {
        logic              wr_en;
        logic [ADDR_W-1:0] addr;
        rgb888_t           pixel;
    } pixel_write_t;

    // count runs 1 to LINE_DEPTH
    typedef struct packed {
        logic [ADDR_W-1:0] base;
        logic [ADDR_W:0]   count;
    } line_cmd_t;

endpackage

`default_nettype wire

/* logic/display_link_top.sv */
// serial display link top level
// line buffer, line sequencer with address adder, and pixel serializer
`timescale 1ns/100ps
`default_nettype none

module display_link_top #(
    parameter int LINE_DEPTH = display_link_pkg::LINE_DEPTH,
    parameter int ADDR_W     = display_link_pkg::ADDR_W
) (
    input  wire logic                           clk,
    input  wire logic                           rst_n,
    input  wire display_link_pkg::pixel_write_t pix_wr,
    input  wire logic                           line_start,
    input  wire display_link_pkg::line_cmd_t    line_cmd,
    output logic                                serial_data,
    output logic                                serial_clk,
    output logic                                serial_frame,
    output logic                                line_busy,
    output logic                                line_done
);

    logic                      rd_en;
    logic [ADDR_W-1:0]         rd_addr;
    display_link_pkg::rgb888_t rd_pixel;
    display_link_pkg::rgb888_t tx_pixel;
    logic                      start_tx;
    logic                      tx_done;

    pixel_line_ram #(
        .LINE_DEPTH (LINE_DEPTH),
        .ADDR_W     (ADDR_W)
    ) u_ram (
        .clk      (clk),
        .rst_n    (rst_n),
        .pix_wr   (pix_wr),
        .rd_en    (rd_en),
        .rd_addr  (rd_addr),
        .rd_pixel (rd_pixel)
    );

    line_sequencer #(
        .ADDR_W (ADDR_W)
    ) u_seq (
        .clk        (clk),
        .rst_n      (rst_n),
        .line_start (line_start),
        .line_cmd   (line_cmd),
        .rd_pixel   (rd_pixel),
        .tx_done    (tx_done),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .start_tx   (start_tx),
        .pixel      (tx_pixel),
        .line_busy  (line_busy),
        .line_done  (line_done)
    );

    // tx_active marks the pixel frame on the link
    serial_display_tx u_tx (
        .clk         (clk),
        .rst_n       (rst_n),
        .start_tx    (start_tx),
        .pixel       (tx_pixel),
        .serial_data (serial_data),
        .serial_clk  (serial_clk),
        .tx_active   (serial_frame),
        .tx_done     (tx_done)
    );

endmodule

`default_nettype wire

/* logic/han_carlson_adder.sv */
// Han-Carlson parallel-prefix adder
// pairs even positions, runs a sparse prefix tree on them, then fills odd positions
`timescale 1ns/100ps
`default_nettype none

module han_carlson_adder #(
    parameter int WIDTH = 5
) (
    input  wire logic [WIDTH-1:0] a,
    input  wire logic [WIDTH-1:0] b,
    input  wire logic             cin,
    output logic [WIDTH-1:0]      sum,
    output logic                  cout
);

    // span-2 and wider levels over the even positions
    localparam int STAGES = $clog2(WIDTH + 1) - 1;

    // position 0 holds the carry in
    wire [WIDTH:0] g0;
    wire [WIDTH:0] p0;
    wire [WIDTH:0] gk [0:STAGES];
    wire [WIDTH:0] pk [0:STAGES];
    wire [WIDTH:0] gf;

    genvar i;
    genvar s;

    assign g0 = {a & b, cin};
    assign p0 = {a ^ b, 1'b0};

    // even position absorbs its odd neighbour below
    for (i = 0; i <= WIDTH; i++) begin : g_pair
        if (i % 2 == 0 && i > 0) begin : g_even
            assign gk[0][i] = g0[i] | (p0[i] & g0[i-1]);
            assign pk[0][i] = p0[i] & p0[i-1];
        end else begin : g_keep
            assign gk[0][i] = g0[i];
            assign pk[0][i] = p0[i];
        end
    end

    // spans 2, 4, ... on even positions only
    for (s = 0; s < STAGES; s++) begin : g_level
        for (i = 0; i <= WIDTH; i++) begin : g_bit
            if (i % 2 == 0 && i >= (2 << s)) begin : g_merge
                assign gk[s+1][i] = gk[s][i] | (pk[s][i] & gk[s][i-(2<<s)]);
                assign pk[s+1][i] = pk[s][i] & pk[s][i-(2<<s)];
            end else begin : g_pass
                assign gk[s+1][i] = gk[s][i];
                assign pk[s+1][i] = pk[s][i];
            end
        end
    end

    // odd positions pick up the finished even group below
    for (i = 0; i <= WIDTH; i++) begin : g_fill
        if (i % 2 == 1) begin : g_odd
            assign gf[i] = gk[STAGES][i] | (pk[STAGES][i] & gk[STAGES][i-1]);
        end else begin : g_done
            assign gf[i] = gk[STAGES][i];
        end
    end

    assign sum  = p0[WIDTH:1] ^ gf[WIDTH-1:0];
    assign cout = gf[WIDTH];

endmodule

`default_nettype wire

/* logic/line_sequencer.sv */
// walks one display line through the buffer
// forms base plus index addresses and hands each pixel to the serializer
`timescale 1ns/100ps
`default_nettype none

module line_sequencer #(
    parameter int ADDR_W = display_link_pkg::ADDR_W
) (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire logic                        line_start,
    input  wire display_link_pkg::line_cmd_t line_cmd,
    input  wire display_link_pkg::rgb888_t   rd_pixel,
    input  wire logic                        tx_done,
    output logic                             rd_en,
    output logic [ADDR_W-1:0]                rd_addr,
    output logic                             start_tx,
    output display_link_pkg::rgb888_t        pixel,
    output logic                             line_busy,
    output logic                             line_done
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_FETCH,
        S_READ,
        S_PRESENT,
        S_WAIT_DONE,
        S_WAIT_CLEAR
    } state_t;

    state_t                      state;
    display_link_pkg::line_cmd_t cmd_q;
    logic [ADDR_W-1:0]           index;
    logic [ADDR_W:0]             index_next;

    assign index_next = {1'b0, index} + 1'b1;

    // carry out dropped so the address wraps around the buffer
    han_carlson_adder #(
        .WIDTH (ADDR_W)
    ) u_addr_add (
        .a    (cmd_q.base),
        .b    (index),
        .cin  (1'b0),
        .sum  (rd_addr),
        .cout ()
    );

    assign rd_en    = (state == S_FETCH);
    assign start_tx = (state == S_PRESENT) || (state == S_WAIT_DONE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= S_IDLE;
            index     <= '0;
            line_busy <= 1'b0;
            line_done <= 1'b0;
        end else begin
            line_done <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (line_start) begin
                        index     <= '0;
                        line_busy <= 1'b1;
                        state     <= S_FETCH;
                    end
                end
                S_FETCH:     state <= S_READ;
                S_READ:      state <= S_PRESENT;
                S_PRESENT:   state <= S_WAIT_DONE;
                S_WAIT_DONE: begin
                    if (tx_done) state <= S_WAIT_CLEAR;
                end
                S_WAIT_CLEAR: begin
                    // next pixel only once the serializer is idle again
                    if (!tx_done) begin
                        if (index_next == cmd_q.count) begin
                            line_busy <= 1'b0;
                            line_done <= 1'b1;
                            state     <= S_IDLE;
                        end else begin
                            index <= index_next[ADDR_W-1:0];
                            state <= S_FETCH;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && line_start) cmd_q <= line_cmd;
        if (state == S_READ) pixel <= rd_pixel;
    end

endmodule

`default_nettype wire

/* logic/pixel_line_ram.sv */
// line buffer for RGB888 pixels
// host write port, registered read port with one cycle latency
`timescale 1ns/100ps
`default_nettype none

module pixel_line_ram #(
    parameter int LINE_DEPTH = display_link_pkg::LINE_DEPTH,
    parameter int ADDR_W     = display_link_pkg::ADDR_W
) (
    input  wire logic                           clk,
    input  wire logic                           rst_n,
    input  wire display_link_pkg::pixel_write_t pix_wr,
    input  wire logic                           rd_en,
    input  wire logic [ADDR_W-1:0]              rd_addr,
    output display_link_pkg::rgb888_t           rd_pixel
);

    display_link_pkg::rgb888_t mem [LINE_DEPTH];

    always_ff @(posedge clk) begin
        if (pix_wr.wr_en) begin
            mem[pix_wr.addr] <= pix_wr.pixel;
        end
    end

    // read sees the old word on a same-cycle write
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_pixel <= '0;
        end else if (rd_en) begin
            rd_pixel <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

/* logic/serial_display_tx.sv */
// RGB888 to RGB565 serializer
// shifts 16 bits MSB first against a generated serial clock
`timescale 1ns/100ps
`default_nettype none

module serial_display_tx (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire logic                      start_tx,
    input  wire display_link_pkg::rgb888_t pixel,
    output logic                           serial_data,
    output logic                           serial_clk,
    output logic                           tx_active,
    output logic                           tx_done
);

    localparam logic [4:0] BITS = 5'd16;

    display_link_pkg::rgb565_u conv;
    display_link_pkg::rgb565_u shift_word;
    logic [4:0]                bit_cnt;
    logic                      accept;

    // truncate each channel to its top bits
    always_comb begin
        conv.fields.red   = pixel.red[7:3];
        conv.fields.green = pixel.green[7:2];
        conv.fields.blue  = pixel.blue[7:3];
    end

    assign accept = start_tx && !tx_active && !tx_done;

    always_ff @(posedge clk) begin
        if (accept) begin
            shift_word <= conv;
        end else if (tx_active && serial_clk) begin
            shift_word.raw <= {shift_word.raw[14:0], 1'b0};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            serial_data <= 1'b0;
            serial_clk  <= 1'b0;
            tx_active   <= 1'b0;
            tx_done     <= 1'b0;
            bit_cnt     <= '0;
        end else if (accept) begin
            // first bit set up while the serial clock is low
            serial_data <= conv.raw[15];
            serial_clk  <= 1'b0;
            tx_active   <= 1'b1;
            bit_cnt     <= '0;
        end else if (tx_active) begin
            if (serial_clk) begin
                // falling edge moves to the next bit
                serial_clk  <= 1'b0;
                serial_data <= shift_word.raw[14];
                bit_cnt     <= bit_cnt + 1'b1;
            end else if (bit_cnt == BITS) begin
                tx_active <= 1'b0;
                tx_done   <= 1'b1;
            end else begin
                serial_clk <= 1'b1;
            end
        end else if (tx_done && !start_tx) begin
            tx_done <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* tb/display_link_tb.sv */
// testbench for the serial display link
// table-driven lines checked against a buffer model and a serial bit collector
`timescale 1ns/100ps
`default_nettype none

module display_link_tb;

    typedef enum int {
        OP_WRITE,
        OP_FILL,
        OP_LINE,
        OP_LINE_BUSY
    } op_t;

    localparam int WAIT_LIMIT = 5000;

    logic                           clk = 1'b0;
    logic                           rst_n;
    display_link_pkg::pixel_write_t pix_wr;
    logic                           line_start;
    display_link_pkg::line_cmd_t    line_cmd;
    logic                           serial_data;
    logic                           serial_clk;
    logic                           serial_frame;
    logic                           line_busy;
    logic                           line_done;

    // stimulus table with one entry per index
    string       tbl_name [$];
    op_t         tbl_op [$];
    int          tbl_addr [$];
    int          tbl_count [$];
    logic [23:0] tbl_pixel [$];

    display_link_pkg::rgb888_t model [32];
    logic [15:0]               got_q [$];
    logic [15:0]               shift_in = '0;
    int                        bits_in = 0;
    logic                      clk_prev = 1'b0;
    logic                      frame_prev = 1'b0;
    int                        frame_cnt = 0;
    int                        done_cnt = 0;
    logic [15:0]               lfsr;
    int                        mismatch_cnt;
    int                        timeout_cnt;

    display_link_top #(
        .LINE_DEPTH (32),
        .ADDR_W     (5)
    ) DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .pix_wr       (pix_wr),
        .line_start   (line_start),
        .line_cmd     (line_cmd),
        .serial_data  (serial_data),
        .serial_clk   (serial_clk),
        .serial_frame (serial_frame),
        .line_busy    (line_busy),
        .line_done    (line_done)
    );

    always #4 clk = ~clk;

    // take a bit on each rising serial clock and pack 16 bits to a frame
    always @(posedge clk) begin
        if (serial_clk && !clk_prev) begin
            check_value("serial_frame during bit", 1, serial_frame);
            shift_in = {shift_in[14:0], serial_data};
            bits_in++;
            if (bits_in == 16) begin
                got_q.push_back(shift_in);
                bits_in = 0;
            end
        end
        if (serial_frame && !frame_prev) frame_cnt++;
        if (line_done) done_cnt++;
        clk_prev   = serial_clk;
        frame_prev = serial_frame;
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    function automatic logic [15:0] to_565(input display_link_pkg::rgb888_t p);
        return {p.red[7:3], p.green[7:2], p.blue[7:3]};
    endfunction

    task automatic random_pixel(output display_link_pkg::rgb888_t p);
        int n;
        p = '0;
        for (n = 0; n < 24; n++) begin
            p = {p[22:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Mismatch %s: expected %0h, actual %0h", name, expected, actual);
            mismatch_cnt++;
        end
    endtask

    task automatic wait_busy(input string name, input logic level);
        int cycles;
        cycles = 0;
        while (line_busy !== level && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (line_busy !== level) begin
            $display("%s: timed out waiting for line_busy to become %0b", name, level);
            timeout_cnt++;
        end
    endtask

    task automatic add_entry(input string name, input op_t op, input int addr,
                             input int count, input logic [23:0] pixel);
        tbl_name.push_back(name);
        tbl_op.push_back(op);
        tbl_addr.push_back(addr);
        tbl_count.push_back(count);
        tbl_pixel.push_back(pixel);
    endtask

    task automatic write_pixel(input int addr, input display_link_pkg::rgb888_t p);
        @(posedge clk);
        pix_wr.wr_en <= 1'b1;
        pix_wr.addr  <= addr[4:0];
        pix_wr.pixel <= p;
        model[addr] = p;
        @(posedge clk);
        pix_wr.wr_en <= 1'b0;
    endtask

    task automatic run_line(input string name, input int base, input int count,
                            input logic poke);
        logic [15:0] exp_q [$];
        int          got_base;
        int          frame_base;
        int          done_base;
        int          i;
        wait_busy(name, 1'b0);
        if (timeout_cnt != 0) return;
        for (i = 0; i < count; i++) begin
            exp_q.push_back(to_565(model[(base + i) % 32]));
        end
        got_base   = got_q.size();
        frame_base = frame_cnt;
        done_base  = done_cnt;
        @(posedge clk);
        line_start     <= 1'b1;
        line_cmd.base  <= base[4:0];
        line_cmd.count <= count[5:0];
        @(posedge clk);
        line_start <= 1'b0;
        wait_busy(name, 1'b1);
        if (timeout_cnt != 0) return;
        if (poke) begin
            // full-line command that must be dropped
            @(posedge clk);
            line_start     <= 1'b1;
            line_cmd.base  <= 5'd0;
            line_cmd.count <= 6'd32;
            @(posedge clk);
            line_start <= 1'b0;
        end
        wait_busy(name, 1'b0);
        if (timeout_cnt != 0) return;
        @(posedge clk);
        check_value({name, " frames"}, count, got_q.size() - got_base);
        check_value({name, " frame strobes"}, count, frame_cnt - frame_base);
        for (i = 0; i < count && got_base + i < got_q.size(); i++) begin
            check_value($sformatf("%s pixel %0d", name, i), exp_q[i], got_q[got_base + i]);
        end
        check_value({name, " done pulses"}, 1, done_cnt - done_base);
        check_value({name, " leftover bits"}, 0, bits_in);
    endtask

    task automatic build_table;
        add_entry("pixel_low_bits", OP_WRITE, 0, 1, 24'h0F070F);
        add_entry("pixel_all_ones", OP_WRITE, 1, 1, 24'hFFFFFF);
        add_entry("single_low_bits", OP_LINE, 0, 1, '0);
        add_entry("single_all_ones", OP_LINE, 1, 1, '0);
        add_entry("fill_middle", OP_FILL, 4, 12, '0);
        add_entry("line_multi", OP_LINE, 4, 6, '0);
        add_entry("fill_wrap", OP_FILL, 28, 8, '0);
        add_entry("line_wrap", OP_LINE, 28, 8, '0);
        add_entry("line_while_busy", OP_LINE_BUSY, 10, 3, '0);
        add_entry("line_before_rewrite", OP_LINE, 2, 1, '0);
        add_entry("rewrite_pixel", OP_WRITE, 2, 1, 24'h123456);
        add_entry("line_after_rewrite", OP_LINE, 2, 1, '0);
    endtask

    initial begin
        int                        i;
        int                        k;
        display_link_pkg::rgb888_t p;
        rst_n        = 1'b0;
        pix_wr       = '0;
        line_start   = 1'b0;
        line_cmd     = '0;
        lfsr         = 16'd17;
        mismatch_cnt = 0;
        timeout_cnt  = 0;
        build_table();
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        check_value("reset serial_data", 0, serial_data);
        check_value("reset serial_clk", 0, serial_clk);
        check_value("reset serial_frame", 0, serial_frame);
        check_value("reset line_busy", 0, line_busy);
        check_value("reset line_done", 0, line_done);
        for (i = 0; i < tbl_name.size(); i++) begin
            case (tbl_op[i])
                OP_WRITE: write_pixel(tbl_addr[i], tbl_pixel[i]);
                OP_FILL: begin
                    for (k = 0; k < tbl_count[i]; k++) begin
                        random_pixel(p);
                        write_pixel((tbl_addr[i] + k) % 32, p);
                    end
                end
                OP_LINE: run_line(tbl_name[i], tbl_addr[i], tbl_count[i], 1'b0);
                OP_LINE_BUSY: run_line(tbl_name[i], tbl_addr[i], tbl_count[i], 1'b1);
                default: ;
            endcase
            if (timeout_cnt != 0) break;
        end
        $display("errors: %0d mismatches, %0d timeouts", mismatch_cnt, timeout_cnt);
        if (mismatch_cnt == 0 && timeout_cnt == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
